//--- hw/sd_host_settings.svh
////////////////////////////////////////////////////////////
// SD host command path settings
// bus geometry, frame length, response timeout and the
// host register map
////////////////////////////////////////////////////////////
`ifndef SD_HOST_SETTINGS_SVH
`define SD_HOST_SETTINGS_SVH

// host bus
`define SD_ADDR_W 8
`define SD_DATA_W 32

// command / response frame
`define SD_ARG_W        32
`define SD_FRAME_LEN    48
`define SD_RESP_TIMEOUT 64   // cycles after tx_done

// register map
`define SD_ADDR_ARG    8'h08
`define SD_ADDR_CMD    8'h0C
`define SD_ADDR_RESP   8'h10
`define SD_ADDR_PSTATE 8'h24
`define SD_ADDR_NISR   8'h30
`define SD_ADDR_EISR   8'h34

`endif

//--- hw/sd_reg_pkg.sv
////////////////////////////////////////////////////////////
// SD host register side types
// host bus request and the interrupt status fields
////////////////////////////////////////////////////////////
`include "sd_host_settings.svh"

package sd_reg_pkg;

   typedef logic [`SD_ADDR_W-1:0] reg_addr_t;
   typedef logic [`SD_DATA_W-1:0] reg_data_t;

   // one bus cycle from the host, 42 bits
   typedef struct packed {
      logic      wr_en;
      logic      rd_en;
      reg_addr_t addr;
      reg_data_t wr_data;
   } bus_req_t;

   // sticky status bits
   // cmd_complete lives in NISR, the errors in EISR
   typedef struct packed {
      logic cmd_complete;   // NISR[0]
      logic timeout_err;    // EISR[0]
      logic crc_err;        // EISR[1]
      logic index_err;      // EISR[2]
   } sd_status_t;

endpackage

//--- hw/sd_cmd_pkg.sv
////////////////////////////////////////////////////////////
// SD host command side types
// command request, response result and FSM states
////////////////////////////////////////////////////////////
`include "sd_host_settings.svh"

package sd_cmd_pkg;

   typedef logic [5:0]           cmd_index_t;
   typedef logic [`SD_ARG_W-1:0] cmd_arg_t;
   typedef logic [6:0]           crc7_t;

   typedef enum logic [1:0] {
      RESP_NONE = 2'd0,
      RESP_48   = 2'd1
   } resp_type_e;

   // held stable by the decode block for the whole command
   typedef struct packed {
      cmd_index_t index;
      cmd_arg_t   arg;
      resp_type_e resp_type;
   } sd_cmd_req_t;

   // valid only in the resp_done cycle
   typedef struct packed {
      cmd_index_t index;
      cmd_arg_t   arg;
      logic       crc_ok;
      logic       index_ok;
      logic       timeout;
   } sd_resp_t;

   typedef enum logic {SER_IDLE, SER_SHIFT} ser_state_e;

   typedef enum logic [1:0] {CAP_IDLE, CAP_WAIT, CAP_RECV, CAP_DONE} cap_state_e;

endpackage

//--- hw/sd_crc7.sv
////////////////////////////////////////////////////////////
// CRC7 generator, x^7 + x^3 + 1
// one bit per enabled cycle, MSB of the frame first
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sd_crc7 import sd_cmd_pkg::*; (
   input  logic  clk,
   input  logic  arst_n,
   input  logic  clear,    // start of a new frame
   input  logic  bit_en,
   input  logic  bit_in,
   output crc7_t crc
);

   logic fb;

   assign fb = bit_in ^ crc[6];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         crc <= '0;
      else if (clear)
         crc <= '0;
      else if (bit_en)
         crc <= {crc[5:3], crc[2] ^ fb, crc[1:0], fb};   // tap at x^3
   end

endmodule

//--- hw/sd_reg_decode.sv
////////////////////////////////////////////////////////////
// SD host register block
// bus decode, ARG/CMD/RESP/PSTATE/NISR/EISR, command start
// detection and the interrupt level
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "sd_host_settings.svh"

module sd_reg_decode import sd_reg_pkg::*, sd_cmd_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  bus_req_t    bus,
   output reg_data_t   rd_data,
   output sd_cmd_req_t cmd_req,
   output logic        cmd_start,
   input  logic        resp_done,
   input  sd_resp_t    resp,
   output logic        irq
);

   logic       wr_arg;
   logic       wr_cmd;
   logic       wr_nisr;
   logic       wr_eisr;
   logic       start;
   logic       cmd_busy;
   cmd_arg_t   arg_q;
   cmd_arg_t   resp_q;
   sd_status_t status_q;
   sd_status_t status_set;
   sd_status_t status_clr;
   reg_data_t  rd_mux;

   assign wr_arg  = bus.wr_en && (bus.addr == `SD_ADDR_ARG);
   assign wr_cmd  = bus.wr_en && (bus.addr == `SD_ADDR_CMD);
   assign wr_nisr = bus.wr_en && (bus.addr == `SD_ADDR_NISR);
   assign wr_eisr = bus.wr_en && (bus.addr == `SD_ADDR_EISR);

   assign start = wr_cmd && bus.wr_data[15] && !cmd_busy;   // dropped while busy

   ////////////////////////////////////////////////////////////
   // host registers
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         arg_q     <= '0;
         cmd_req   <= '0;
         cmd_start <= 1'b0;
         cmd_busy  <= 1'b0;
         resp_q    <= '0;
      end else begin
         cmd_start <= start;
         if (wr_arg)
            arg_q <= bus.wr_data;
         if (start) begin
            cmd_req.index     <= bus.wr_data[13:8];
            cmd_req.arg       <= arg_q;
            cmd_req.resp_type <= (bus.wr_data[1:0] == 2'b00) ? RESP_NONE : RESP_48;
            cmd_busy          <= 1'b1;
         end else if (resp_done) begin
            cmd_busy <= 1'b0;
         end
         if (resp_done)
            resp_q <= resp.arg;
      end
   end

   // results in, write-1-to-clear out
   always_comb begin
      status_set = '0;
      if (resp_done) begin
         status_set.cmd_complete = 1'b1;
         status_set.timeout_err  = resp.timeout;
         status_set.crc_err      = !resp.timeout && !resp.crc_ok;
         status_set.index_err    = !resp.timeout && !resp.index_ok;
      end
   end

   always_comb begin
      status_clr = '0;
      if (wr_nisr)
         status_clr.cmd_complete = bus.wr_data[0];
      if (wr_eisr) begin
         status_clr.timeout_err = bus.wr_data[0];
         status_clr.crc_err     = bus.wr_data[1];
         status_clr.index_err   = bus.wr_data[2];
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         status_q <= '0;
      else
         status_q <= (status_q & ~status_clr) | status_set;   // new event wins
   end

   assign irq = |status_q;

   ////////////////////////////////////////////////////////////
   // read side
   ////////////////////////////////////////////////////////////
   always_comb begin
      case (bus.addr)
         `SD_ADDR_ARG:    rd_mux = reg_data_t'(arg_q);
         `SD_ADDR_CMD:    rd_mux = reg_data_t'({cmd_req.index, 6'h00, cmd_req.resp_type});
         `SD_ADDR_RESP:   rd_mux = reg_data_t'(resp_q);
         `SD_ADDR_PSTATE: rd_mux = reg_data_t'(cmd_busy);
         `SD_ADDR_NISR:   rd_mux = reg_data_t'(status_q.cmd_complete);
         `SD_ADDR_EISR:   rd_mux = reg_data_t'({status_q.index_err, status_q.crc_err,
                                                status_q.timeout_err});
         default:         rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         rd_data <= '0;
      else if (bus.rd_en)
         rd_data <= rd_mux;   // one cycle read latency
   end

   ////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////
   // a second start while busy must neither reach the serializer nor disturb the request
   a_no_start_busy: assert property (
      @(posedge clk) disable iff (!arst_n)
      (wr_cmd && bus.wr_data[15] && cmd_busy) |=> !cmd_start && $stable(cmd_req)
   ) else $error("command register changed or cmd_start issued while busy");

endmodule

//--- hw/sd_cmd_serializer.sv
////////////////////////////////////////////////////////////
// SD command serializer
// sends start, dir, index, arg, CRC7 and end bit on CMD
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "sd_host_settings.svh"

module sd_cmd_serializer import sd_cmd_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        cmd_start,
   input  sd_cmd_req_t cmd_req,
   output logic        cmd_to_card,
   output logic        cmd_to_card_oe,
   output logic        tx_done
);

   localparam int HDR_LEN = `SD_FRAME_LEN - 8;   // bits covered by the CRC

   ser_state_e          state;
   logic [5:0]          bit_cnt;
   logic [HDR_LEN-1:0]  hdr_q;      // header shift register
   logic [5:0]          crc_sel;
   logic                last_bit;
   logic                tx_pend;
   logic                crc_en;
   crc7_t               crc;

   assign last_bit = (state == SER_SHIFT) && (bit_cnt == 6'(`SD_FRAME_LEN - 1));
   assign crc_en   = (state == SER_SHIFT) && (bit_cnt < 6'(HDR_LEN));
   assign crc_sel  = 6'(HDR_LEN + 6) - bit_cnt;   // 6 down to 0 over the CRC field

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= SER_IDLE;
         bit_cnt <= '0;
         tx_pend <= 1'b0;
         tx_done <= 1'b0;
      end else begin
         tx_pend <= last_bit;
         tx_done <= tx_pend;   // one cycle after oe drops
         case (state)
            SER_IDLE: begin
               bit_cnt <= '0;
               if (cmd_start)
                  state <= SER_SHIFT;
            end
            SER_SHIFT: begin
               bit_cnt <= bit_cnt + 6'd1;
               if (last_bit)
                  state <= SER_IDLE;
            end
            default: state <= SER_IDLE;
         endcase
      end
   end

   // payload, loaded at start
   always_ff @(posedge clk) begin
      if (state == SER_IDLE && cmd_start)
         hdr_q <= {1'b0, 1'b1, cmd_req.index, cmd_req.arg};
      else if (state == SER_SHIFT)
         hdr_q <= {hdr_q[HDR_LEN-2:0], 1'b0};
   end

   sd_crc7 crc7_inst (
      .clk    (clk),
      .arst_n (arst_n),
      .clear  (cmd_start),
      .bit_en (crc_en),
      .bit_in (hdr_q[HDR_LEN-1]),
      .crc    (crc)
   );

   ////////////////////////////////////////////////////////////
   // CMD line
   ////////////////////////////////////////////////////////////
   assign cmd_to_card_oe = (state == SER_SHIFT);

   always_comb begin
      if (state != SER_SHIFT)
         cmd_to_card = 1'b1;   // line idles high
      else if (bit_cnt < 6'(HDR_LEN))
         cmd_to_card = hdr_q[HDR_LEN-1];
      else if (!last_bit)
         cmd_to_card = crc[crc_sel[2:0]];
      else
         cmd_to_card = 1'b1;   // end bit
   end

   // oe is high for one whole frame, no gaps
   a_oe_frame: assert property (
      @(posedge clk) disable iff (!arst_n)
      $fell(cmd_to_card_oe) |-> $past(cmd_to_card_oe, `SD_FRAME_LEN) &&
                                !$past(cmd_to_card_oe, `SD_FRAME_LEN + 1)
   ) else $error("oe window is not one frame long");

endmodule

//--- hw/sd_resp_capture.sv
////////////////////////////////////////////////////////////
// SD response capture
// waits for the start bit, shifts in 48 bits, checks CRC7
// and index, reports the result with resp_done
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "sd_host_settings.svh"

module sd_resp_capture import sd_cmd_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        tx_done,
   input  sd_cmd_req_t cmd_req,
   input  logic        cmd_from_card,
   output logic        resp_done,
   output sd_resp_t    resp
);

   localparam int TMO_W = $clog2(`SD_RESP_TIMEOUT + 1);

   cap_state_e                state;
   logic [TMO_W-1:0]          timer;
   logic [5:0]                bit_cnt;
   logic [`SD_FRAME_LEN-1:0]  frame_q;
   logic                      timeout_q;
   logic                      start_seen;
   logic                      crc_en;
   logic                      no_resp;
   crc7_t                     crc;

   assign start_seen = (state == CAP_WAIT) && !cmd_from_card;
   assign crc_en     = start_seen || ((state == CAP_RECV) && (bit_cnt < 6'(`SD_FRAME_LEN - 8)));

   ////////////////////////////////////////////////////////////
   // capture FSM
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= CAP_IDLE;
         timer     <= '0;
         bit_cnt   <= '0;
         timeout_q <= 1'b0;
      end else begin
         case (state)
            CAP_IDLE: begin
               timer   <= '0;
               bit_cnt <= '0;
               if (tx_done) begin
                  timeout_q <= 1'b0;
                  state     <= (cmd_req.resp_type == RESP_NONE) ? CAP_DONE : CAP_WAIT;
               end
            end
            CAP_WAIT: begin
               if (start_seen) begin
                  bit_cnt <= 6'd1;   // start bit already in
                  state   <= CAP_RECV;
               end else if (timer == TMO_W'(`SD_RESP_TIMEOUT - 1)) begin
                  timeout_q <= 1'b1;   // card never answered
                  state     <= CAP_DONE;
               end else begin
                  timer <= timer + 1'b1;
               end
            end
            CAP_RECV: begin
               bit_cnt <= bit_cnt + 6'd1;
               if (bit_cnt == 6'(`SD_FRAME_LEN - 1))
                  state <= CAP_DONE;   // end bit sampled
            end
            CAP_DONE: state <= CAP_IDLE;
            default:  state <= CAP_IDLE;
         endcase
      end
   end

   // response bits, MSB first
   always_ff @(posedge clk) begin
      if (tx_done)
         frame_q <= '0;
      else if (start_seen || state == CAP_RECV)
         frame_q <= {frame_q[`SD_FRAME_LEN-2:0], cmd_from_card};
   end

   sd_crc7 crc7_inst (
      .clk    (clk),
      .arst_n (arst_n),
      .clear  (tx_done),
      .bit_en (crc_en),
      .bit_in (cmd_from_card),
      .crc    (crc)
   );

   ////////////////////////////////////////////////////////////
   // result
   ////////////////////////////////////////////////////////////
   assign no_resp   = (cmd_req.resp_type == RESP_NONE) || timeout_q;   // nothing to check
   assign resp_done = (state == CAP_DONE);

   always_comb begin
      resp.index    = frame_q[45:40];
      resp.arg      = frame_q[39:8];
      resp.crc_ok   = no_resp || (frame_q[7:1] == crc);
      resp.index_ok = no_resp || (frame_q[45:40] == cmd_req.index);
      resp.timeout  = timeout_q;
   end

   a_done_pulse: assert property (
      @(posedge clk) disable iff (!arst_n)
      resp_done |=> !resp_done
   ) else $error("resp_done wider than one cycle");

endmodule

//--- hw/sd_host.sv
////////////////////////////////////////////////////////////
// SD host controller, command path top
// register decode, command serializer, response capture
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sd_host import sd_reg_pkg::*, sd_cmd_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,
   input  bus_req_t  bus,
   output reg_data_t rd_data,
   input  logic      cmd_from_card,
   output logic      cmd_to_card,
   output logic      cmd_to_card_oe,
   output logic      irq
);

   sd_cmd_req_t cmd_req;
   logic        cmd_start;
   logic        tx_done;
   logic        resp_done;
   sd_resp_t    resp;

   // decode
   sd_reg_decode decode_inst (
      .clk       (clk),
      .arst_n    (arst_n),
      .bus       (bus),
      .rd_data   (rd_data),
      .cmd_req   (cmd_req),
      .cmd_start (cmd_start),
      .resp_done (resp_done),
      .resp      (resp),
      .irq       (irq)
   );

   // execute
   sd_cmd_serializer serializer_inst (
      .clk            (clk),
      .arst_n         (arst_n),
      .cmd_start      (cmd_start),
      .cmd_req        (cmd_req),
      .cmd_to_card    (cmd_to_card),
      .cmd_to_card_oe (cmd_to_card_oe),
      .tx_done        (tx_done)
   );

   // result
   sd_resp_capture capture_inst (
      .clk           (clk),
      .arst_n        (arst_n),
      .tx_done       (tx_done),
      .cmd_req       (cmd_req),
      .cmd_from_card (cmd_from_card),
      .resp_done     (resp_done),
      .resp          (resp)
   );

endmodule

//--- bench/sd_host_checker.sv
////////////////////////////////////////////////////////////
// SD host checker
// captures the CMD frame and compares bus reads with the
// expected results of the running test
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "sd_host_settings.svh"

module sd_host_checker import sd_reg_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  bus_req_t    bus,
   input  reg_data_t   rd_data,
   input  logic        cmd_to_card,
   input  logic        cmd_to_card_oe,
   input  logic        irq,
   input  logic        test_start,
   input  logic        test_end,
   input  int          test_num,
   input  logic [95:0] test_name,
   input  logic [47:0] exp_frame,
   input  reg_data_t   exp_resp,
   input  logic [2:0]  exp_eisr,
   output int          errors
);

   logic [47:0] frame_q;
   logic        oe_q;
   logic        done_seen;   // completion seen in this test
   logic        nisr_clr;
   logic [2:0]  eisr_clr;
   logic        rd_pend;
   reg_addr_t   rd_addr;
   reg_data_t   rd_exp;
   int          frame_cnt;
   int          errs_at_start;

   // register contents at this point of the test
   function automatic reg_data_t expected_read(input reg_addr_t addr, input logic done);
      case (addr)
         `SD_ADDR_RESP:   return exp_resp;
         `SD_ADDR_NISR:   return reg_data_t'(done && !nisr_clr);
         `SD_ADDR_EISR:   return done ? reg_data_t'(exp_eisr & ~eisr_clr) : '0;
         `SD_ADDR_PSTATE: return reg_data_t'(!done);   // busy until completion
         default:         return '0;
      endcase
   endfunction

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         frame_q       = '0;
         oe_q          = 1'b0;
         done_seen     = 1'b0;
         nisr_clr      = 1'b0;
         eisr_clr      = '0;
         rd_pend       = 1'b0;
         rd_addr       = '0;
         rd_exp        = '0;
         frame_cnt     = 0;
         errs_at_start = 0;
         errors        = 0;
      end else begin
         // read data is valid one cycle after rd_en
         if (rd_pend && rd_data !== rd_exp) begin
            $display("ERROR test %0d: rd_data at 0x%02h = 0x%08h, expected 0x%08h",
                     test_num, rd_addr, rd_data, rd_exp);
            errors++;
         end
         if (test_start) begin
            frame_cnt     = 0;
            done_seen     = 1'b0;
            nisr_clr      = 1'b0;
            eisr_clr      = '0;
            errs_at_start = errors;
         end
         done_seen = done_seen || irq;
         rd_pend   = bus.rd_en;
         rd_addr   = bus.addr;
         rd_exp    = expected_read(bus.addr, done_seen);

         ////////////////////////////////////////////////////////////
         // status clears and irq
         ////////////////////////////////////////////////////////////
         if (bus.wr_en && bus.addr == `SD_ADDR_NISR) begin
            if (irq !== 1'b1) begin
               $display("ERROR test %0d: irq = 0x%0h before the status clear, expected 0x1",
                        test_num, irq);
               errors++;
            end
            nisr_clr = nisr_clr | bus.wr_data[0];
         end
         if (bus.wr_en && bus.addr == `SD_ADDR_EISR)
            eisr_clr = eisr_clr | bus.wr_data[2:0];

         // frame capture while the host drives CMD
         if (cmd_to_card_oe) begin
            if (!oe_q)
               frame_cnt++;
            frame_q = {frame_q[46:0], cmd_to_card};
         end
         oe_q = cmd_to_card_oe;

         if (test_end) begin
            if (frame_cnt != 1) begin
               $display("test %0d: %0d command frames were sent, expected exactly one",
                        test_num, frame_cnt);
               errors++;
            end
            if (frame_q !== exp_frame) begin
               $display("ERROR test %0d: cmd_to_card frame = 0x%012h, expected 0x%012h",
                        test_num, frame_q, exp_frame);
               errors++;
            end
            if (irq !== 1'b0) begin
               $display("ERROR test %0d: irq = 0x%0h after the status clear, expected 0x0",
                        test_num, irq);
               errors++;
            end
            $display("test %0d %0s: %s", test_num, test_name,
                     (errors == errs_at_start) ? "passed" : "failed");
         end
      end
   end

endmodule

//--- bench/tb_sd_host.sv
////////////////////////////////////////////////////////////
// SD host command path testbench
// bus stimulus from the test table, card response model,
// watchdog and the final verdict
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "sd_host_settings.svh"

module tb_sd_host import sd_reg_pkg::*, sd_cmd_pkg::*; ();

   localparam int MAX_TESTS    = 32;
   localparam int CYC_PER_TEST = `SD_FRAME_LEN + `SD_RESP_TIMEOUT + 100;

   // card response modes
   localparam logic [1:0] MODE_GOOD      = 2'd0;
   localparam logic [1:0] MODE_BAD_CRC   = 2'd1;
   localparam logic [1:0] MODE_BAD_INDEX = 2'd2;
   localparam logic [1:0] MODE_NONE      = 2'd3;

   typedef struct packed {
      logic [95:0] name;
      cmd_index_t  index;
      cmd_arg_t    arg;
      logic [1:0]  rtype;
      logic [1:0]  mode;
      cmd_arg_t    rarg;    // argument the card answers with
      logic [47:0] frame;   // expected command frame
      reg_data_t   resp;
      logic [2:0]  eisr;
   } test_vec_t;

   logic        clk;
   logic        arst_n;
   bus_req_t    bus;
   reg_data_t   rd_data;
   logic        cmd_from_card;
   logic        cmd_to_card;
   logic        cmd_to_card_oe;
   logic        irq;
   logic        test_start;
   logic        test_end;
   int          test_num;
   logic [95:0] test_name;
   logic [47:0] exp_frame;
   reg_data_t   exp_resp;
   logic [2:0]  exp_eisr;
   int          chk_errors;
   int          tb_errors;
   int          n_tests;
   logic        loaded;
   test_vec_t   tests [MAX_TESTS];

   sd_host sd_host_inst (
      .clk            (clk),
      .arst_n         (arst_n),
      .bus            (bus),
      .rd_data        (rd_data),
      .cmd_from_card  (cmd_from_card),
      .cmd_to_card    (cmd_to_card),
      .cmd_to_card_oe (cmd_to_card_oe),
      .irq            (irq)
   );

   sd_host_checker checker_inst (
      .clk            (clk),
      .arst_n         (arst_n),
      .bus            (bus),
      .rd_data        (rd_data),
      .cmd_to_card    (cmd_to_card),
      .cmd_to_card_oe (cmd_to_card_oe),
      .irq            (irq),
      .test_start     (test_start),
      .test_end       (test_end),
      .test_num       (test_num),
      .test_name      (test_name),
      .exp_frame      (exp_frame),
      .exp_resp       (exp_resp),
      .exp_eisr       (exp_eisr),
      .errors         (chk_errors)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period
   end

   ////////////////////////////////////////////////////////////
   // test table and card model helpers
   ////////////////////////////////////////////////////////////
   function automatic logic [95:0] pack_name(input string s);
      logic [95:0] v;
      v = '0;
      for (int i = 0; i < s.len() && i < 12; i++)
         v = {v[87:0], s[i]};
      return v;
   endfunction

   // x^7 + x^3 + 1, zero start, MSB first
   function automatic crc7_t frame_crc7(input logic [39:0] hdr);
      crc7_t c;
      logic  fb;
      c = '0;
      for (int i = 39; i >= 0; i--) begin
         fb = hdr[i] ^ c[6];
         c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
      end
      return c;
   endfunction

   function automatic logic [47:0] response_frame(input test_vec_t t);
      cmd_index_t  idx;
      logic [39:0] hdr;
      crc7_t       c;
      idx = (t.mode == MODE_BAD_INDEX) ? (t.index ^ 6'h01) : t.index;
      hdr = {2'b00, idx, t.rarg};   // start 0, transmission bit 0
      c   = frame_crc7(hdr);
      if (t.mode == MODE_BAD_CRC)
         c = c ^ 7'h01;
      return {hdr, c, 1'b1};
   endfunction

   task automatic load_tests();
      int          fd;
      int          n;
      string       line;
      string       name_s;
      cmd_index_t  idx;
      cmd_arg_t    arg;
      logic [1:0]  rtype;
      logic [1:0]  mode;
      cmd_arg_t    rarg;
      logic [47:0] frame;
      reg_data_t   resp;
      logic [2:0]  eisr;
      fd = $fopen("bench/sd_host_input.txt", "r");
      if (fd == 0) begin
         $display("cannot open the stimulus file bench/sd_host_input.txt");
         tb_errors++;
         return;
      end
      while (!$feof(fd) && n_tests < MAX_TESTS) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 2 || line[0] == "#")
            continue;   // blank or comment
         n = $sscanf(line, "%s %h %h %h %h %h %h %h %h",
                     name_s, idx, arg, rtype, mode, rarg, frame, resp, eisr);
         if (n != 9) begin
            $display("malformed stimulus line: %s", line);
            tb_errors++;
            continue;
         end
         tests[n_tests] = '{pack_name(name_s), idx, arg, rtype, mode, rarg, frame, resp, eisr};
         n_tests++;
      end
      $fclose(fd);
      if (n_tests == 0) begin
         $display("the stimulus file holds no tests");
         tb_errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // bus and card tasks, all start and end 1 ns after a rising edge
   ////////////////////////////////////////////////////////////
   task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
      bus = '{wr_en: 1'b1, rd_en: 1'b0, addr: addr, wr_data: data};
      @(posedge clk);
      #1 bus = '0;
   endtask

   task automatic bus_read(input reg_addr_t addr);
      bus = '{wr_en: 1'b0, rd_en: 1'b1, addr: addr, wr_data: '0};
      @(posedge clk);
      #1 bus = '0;
   endtask

   task automatic wait_oe_low(input int t);
      int n;
      n = 0;
      while (cmd_to_card_oe && n < 2 * `SD_FRAME_LEN) begin
         @(posedge clk);
         #1 n++;
      end
      if (cmd_to_card_oe) begin
         $display("test %0d: command frame did not end in time", t);
         tb_errors++;
      end
   endtask

   task automatic card_respond(input logic [47:0] frame);
      repeat (5) @(posedge clk);   // card turnaround
      #1;
      for (int i = 47; i >= 0; i--) begin
         cmd_from_card = frame[i];
         @(posedge clk);
         #1;
      end
      cmd_from_card = 1'b1;
   endtask

   task automatic wait_irq(input int t);
      int n;
      n = 0;
      while (!irq && n < `SD_RESP_TIMEOUT + 2 * `SD_FRAME_LEN) begin
         @(posedge clk);
         #1 n++;
      end
      if (!irq) begin
         $display("test %0d: command never completed, irq stayed low", t);
         tb_errors++;
      end
   endtask

   task automatic run_test(input int t);
      test_vec_t v;
      reg_data_t cmd_word;
      v        = tests[t];
      cmd_word = {16'h0000, 1'b1, 1'b0, v.index, 6'h00, v.rtype};   // bit 15 new command
      test_num   = t;
      test_name  = v.name;
      exp_frame  = v.frame;
      exp_resp   = v.resp;
      exp_eisr   = v.eisr;
      test_start = 1'b1;
      @(posedge clk);
      #1 test_start = 1'b0;
      bus_write(`SD_ADDR_ARG, v.arg);
      bus_write(`SD_ADDR_CMD, cmd_word);
      bus_read(`SD_ADDR_PSTATE);
      bus_write(`SD_ADDR_CMD, cmd_word);   // while busy, dropped
      wait_oe_low(t);
      if (v.mode != MODE_NONE)
         card_respond(response_frame(v));
      wait_irq(t);
      bus_read(`SD_ADDR_RESP);
      bus_read(`SD_ADDR_NISR);
      bus_read(`SD_ADDR_EISR);
      bus_read(`SD_ADDR_PSTATE);
      bus_write(`SD_ADDR_NISR, 32'h1);
      bus_write(`SD_ADDR_EISR, 32'h7);
      bus_read(`SD_ADDR_NISR);
      bus_read(`SD_ADDR_EISR);
      test_end = 1'b1;
      @(posedge clk);
      #1 test_end = 1'b0;
   endtask

   initial begin
      arst_n        = 1'b0;
      bus           = '0;
      cmd_from_card = 1'b1;   // idle high
      test_start    = 1'b0;
      test_end      = 1'b0;
      test_num      = 0;
      test_name     = '0;
      exp_frame     = '0;
      exp_resp      = '0;
      exp_eisr      = '0;
      tb_errors     = 0;
      n_tests       = 0;
      loaded        = 1'b0;
      load_tests();
      loaded = 1'b1;
      repeat (8) @(posedge clk);
      #1 arst_n = 1'b1;
      for (int t = 0; t < n_tests; t++)
         run_test(t);
      repeat (4) @(posedge clk);
      $display("tests run: %0d, errors: %0d", n_tests, chk_errors + tb_errors);
      if (chk_errors + tb_errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

   // watchdog
   initial begin
      wait (loaded);
      repeat (16 + n_tests * CYC_PER_TEST) @(posedge clk);
      $display("watchdog: run did not finish within %0d cycles", 16 + n_tests * CYC_PER_TEST);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

//--- bench/sd_host_input.txt
# name index arg resp_type mode resp_arg exp_frame exp_resp exp_eisr (all hex but name)
# resp_type 0 none 1 48-bit, mode 0 good 1 bad CRC 2 wrong index 3 no response
cmd0_none    00 00000000 0 3 00000000 400000000095 00000000 0
cmd8_good    08 000001aa 1 0 000001aa 48000001aa87 000001aa 0
cmd55_good   37 00000000 1 0 00000120 770000000065 00000120 0
acmd41_crc   29 40000000 1 1 00ff8000 694000000077 00ff8000 2
cmd17_index  11 00000000 1 2 00000900 510000000055 00000900 4
cmd58_tmo    3a 00000000 1 3 00000000 7a00000000fd 00000000 1

//--- build.f
+incdir+hw
hw/sd_reg_pkg.sv
hw/sd_cmd_pkg.sv
hw/sd_crc7.sv
hw/sd_reg_decode.sv
hw/sd_cmd_serializer.sv
hw/sd_resp_capture.sv
hw/sd_host.sv
bench/sd_host_checker.sv
bench/tb_sd_host.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the SD host command path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_sd_host
out=$(./obj_dir/Vtb_sd_host)
echo "$out"
if grep -qx "PASS: all tests" <<< "$out"; then
   exit 0
fi
exit 1
